/* common/feature_pkg.sv */
package feature_pkg;

    // default frame geometry and detector setting
    parameter int IMG_W_DEF     = 16;
    parameter int IMG_H_DEF     = 16;
    parameter int THRESHOLD_DEF = 6;

    // one grayscale pixel
    typedef logic [7:0] pix_t;

    // pixel minus blurred pixel
    typedef logic signed [8:0] dog_t;

    // one full image row with column 0 at the low end
    typedef struct packed {
        pix_t [IMG_W_DEF-1:0] px;
    } pix_row_t;

    // one full row of DoG values
    typedef struct packed {
        dog_t [IMG_W_DEF-1:0] d;
    } dog_row_t;

    // keypoint position with the row in the upper byte
    typedef struct packed {
        logic [7:0] row;
        logic [7:0] col;
    } keypoint_t;

    // top-level sequencer phases
    typedef enum logic [2:0] {
        phase_idle   = 3'd0,
        phase_load   = 3'd1,
        phase_blur   = 3'd2,
        phase_detect = 3'd3,
        phase_finish = 3'd4
    } phase_e;

endpackage

/* verilog/row_mem.sv */
module row_mem #(
    parameter int DEPTH = feature_pkg::IMG_H_DEF
) (
    input  logic                      clk,
    input  logic                      we,
    input  logic [$clog2(DEPTH)-1:0]  addr,
    input  feature_pkg::pix_row_t     din,
    output feature_pkg::pix_row_t     dout
);

    feature_pkg::pix_row_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];   // old word on a write cycle
    end

endmodule

/* verilog/line_buffer.sv */
module line_buffer #(
    parameter type row_t = feature_pkg::pix_row_t
) (
    input  logic clk,
    input  logic rst_n,
    input  logic shift,
    input  logic zero_fill,
    input  row_t row_in,
    output row_t top,
    output row_t mid,
    output row_t bot
);

    row_t row_next;

    assign row_next = zero_fill ? row_t'('0) : row_in;   // padding row at the border

    // oldest row on top, newest row at the bottom
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top <= '0;
            mid <= '0;
            bot <= '0;
        end else if (shift) begin
            top <= mid;
            mid <= bot;
            bot <= row_next;
        end
    end

endmodule

/* gaussian/gaussian_blur.sv */
module gaussian_blur #(
    parameter int IMG_W = feature_pkg::IMG_W_DEF,
    parameter int IMG_H = feature_pkg::IMG_H_DEF
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    output logic [$clog2(IMG_H)-1:0]  img_addr,
    input  feature_pkg::pix_row_t     img_row,
    output logic [$clog2(IMG_H)-1:0]  blur_addr,
    output logic                      blur_we,
    output feature_pkg::pix_row_t     blur_row,
    output logic                      done
);

    localparam int AW = $clog2(IMG_H);
    localparam int CW = $clog2(IMG_H + 3);

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_push,
        st_fin
    } state_t;

    state_t                state;
    logic [CW-1:0]         cnt;        // rows pushed into the window so far
    logic                  shift;
    logic                  zero_fill;
    feature_pkg::pix_row_t win_top;
    feature_pkg::pix_row_t win_mid;
    feature_pkg::pix_row_t win_bot;
    logic [9:0]            vsum [IMG_W + 2];
    logic [11:0]           hsum [IMG_W];

    // a zero row goes in before row 0 and after row IMG_H-1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        cnt   <= '0;
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (cnt == CW'(IMG_H + 2)) begin
                        state <= st_fin;   // last row written this cycle
                    end else begin
                        state <= st_push;
                    end
                end
                st_push: begin
                    cnt   <= cnt + 1'b1;
                    state <= st_fetch;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign img_addr  = (cnt >= 1 && cnt <= IMG_H) ? AW'(cnt - 1'b1) : '0;
    assign shift     = (state == st_push);
    assign zero_fill = (cnt == '0) || (cnt == CW'(IMG_H + 1));

    // middle row is complete once three rows sit in the window
    assign blur_we   = (state == st_fetch) && (cnt >= 3);
    assign blur_addr = AW'(cnt - CW'(3));
    assign done      = (state == st_fin);

    line_buffer #(
        .row_t (feature_pkg::pix_row_t)
    ) i_line_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .shift     (shift),
        .zero_fill (zero_fill),
        .row_in    (img_row),
        .top       (win_top),
        .mid       (win_mid),
        .bot       (win_bot)
    );

    // vertical 1 2 1 pass with one zero column on each side
    always_comb begin
        vsum[0]         = '0;
        vsum[IMG_W + 1] = '0;
        for (int c = 0; c < IMG_W; c++) begin
            vsum[c + 1] = 10'(win_top.px[c]) + 10'({win_mid.px[c], 1'b0})
                        + 10'(win_bot.px[c]);
        end
    end

    // horizontal 1 2 1 pass then divide by the weight sum of 16
    always_comb begin
        blur_row = '0;
        for (int c = 0; c < IMG_W; c++) begin
            hsum[c] = 12'(vsum[c]) + 12'({vsum[c + 1], 1'b0}) + 12'(vsum[c + 2]);
            blur_row.px[c] = hsum[c][11:4];
        end
    end

endmodule

/* detect/keypoint_detect.sv */
module keypoint_detect #(
    parameter int IMG_W     = feature_pkg::IMG_W_DEF,
    parameter int IMG_H     = feature_pkg::IMG_H_DEF,
    parameter int THRESHOLD = feature_pkg::THRESHOLD_DEF
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    output logic [$clog2(IMG_H)-1:0]  row_addr,
    input  feature_pkg::pix_row_t     img_row,
    input  feature_pkg::pix_row_t     blur_row,
    output logic                      kp_valid,
    output feature_pkg::keypoint_t    kp,
    output logic                      done
);

    localparam int AW = $clog2(IMG_H);
    localparam int RW = $clog2(IMG_H + 1);

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_push,
        st_mask,
        st_drain,
        st_fin
    } state_t;

    state_t                state;
    logic [RW-1:0]         rd_cnt;       // rows pushed into the DoG window
    feature_pkg::dog_row_t dog_in;
    feature_pkg::dog_row_t win [3];
    logic [IMG_W-1:0]      cand;
    logic [IMG_W-1:0]      scan_mask;    // candidates of the row being emitted
    logic [IMG_W-1:0]      scan_clr;
    logic [7:0]            scan_row;
    logic [7:0]            low_col;
    logic                  load_scan;

    assign row_addr = AW'(rd_cnt);

    always_comb begin
        dog_in = '0;
        for (int c = 0; c < IMG_W; c++) begin
            dog_in.d[c] = $signed({1'b0, img_row.px[c]}) - $signed({1'b0, blur_row.px[c]});
        end
    end

    line_buffer #(
        .row_t (feature_pkg::dog_row_t)
    ) i_line_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .shift     (state == st_push),
        .zero_fill (1'b0),                // interior centres never see padding
        .row_in    (dog_in),
        .top       (win[0]),
        .mid       (win[1]),
        .bot       (win[2])
    );

    // strict 3x3 extremum above threshold in interior columns only
    always_comb begin
        feature_pkg::dog_t ctr;
        feature_pkg::dog_t nb;
        logic              is_max;
        logic              is_min;
        cand = '0;
        for (int c = 1; c < IMG_W - 1; c++) begin
            ctr    = win[1].d[c];
            is_max = 1'b1;
            is_min = 1'b1;
            for (int r = 0; r < 3; r++) begin
                for (int dc = -1; dc <= 1; dc++) begin
                    nb = win[r].d[c + dc];
                    if (r != 1 || dc != 0) begin
                        is_max = is_max & (ctr > nb);
                        is_min = is_min & (ctr < nb);
                    end
                end
            end
            cand[c] = (ctr > THRESHOLD || ctr < -THRESHOLD) && (is_max || is_min);
        end
    end

    // lowest set bit goes out first
    always_comb begin
        low_col = '0;
        for (int c = IMG_W - 1; c >= 0; c--) begin
            if (scan_mask[c]) begin
                low_col = 8'(c);
            end
        end
    end

    assign scan_clr  = scan_mask & (scan_mask - 1'b1);
    assign load_scan = (state == st_mask) && (scan_clr == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            rd_cnt    <= '0;
            scan_mask <= '0;
            scan_row  <= '0;
            kp_valid  <= 1'b0;
        end else begin
            kp_valid  <= |scan_mask;
            scan_mask <= load_scan ? cand : scan_clr;
            if (load_scan) begin
                scan_row <= 8'(rd_cnt - 2'd2);   // window centre row
            end
            case (state)
                st_idle: begin
                    if (start) begin
                        rd_cnt <= '0;
                        state  <= st_read;
                    end
                end
                st_read: begin
                    state <= st_push;
                end
                st_push: begin
                    rd_cnt <= rd_cnt + 1'b1;
                    state  <= (rd_cnt >= RW'(2)) ? st_mask : st_read;
                end
                st_mask: begin
                    if (load_scan) begin
                        state <= (rd_cnt == RW'(IMG_H)) ? st_drain : st_read;
                    end
                end
                st_drain: begin
                    if (scan_mask == '0) begin
                        state <= st_fin;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        kp.row <= scan_row;
        kp.col <= low_col;
    end

    assign done = (state == st_fin);

endmodule

/* verilog/feature_core.sv */
module feature_core #(
    parameter int IMG_W     = feature_pkg::IMG_W_DEF,
    parameter int IMG_H     = feature_pkg::IMG_H_DEF,
    parameter int THRESHOLD = feature_pkg::THRESHOLD_DEF
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic [15:0]             in_data,
    output logic                    out_valid,
    output feature_pkg::keypoint_t  out_data,
    output logic                    done
);

    localparam int AW = $clog2(IMG_H);
    localparam int WW = $clog2(IMG_W);

    feature_pkg::phase_e   phase;
    feature_pkg::phase_e   phase_nxt;

    logic [WW-1:0]         wcnt;       // word within the row
    logic [AW-1:0]         lrow;       // row being loaded
    feature_pkg::pix_row_t asm_row;
    feature_pkg::pix_row_t ld_row;
    logic                  accept;
    logic                  load_we;
    logic                  load_last;

    logic [AW-1:0]         img_addr;
    logic                  img_we;
    feature_pkg::pix_row_t img_dout;
    logic [AW-1:0]         blur_addr;
    logic                  blur_we;
    feature_pkg::pix_row_t blur_din;
    feature_pkg::pix_row_t blur_dout;

    logic [AW-1:0]         gb_img_addr;
    logic [AW-1:0]         gb_blur_addr;
    logic                  gb_blur_we;
    logic                  gb_done;
    logic [AW-1:0]         kd_row_addr;
    logic                  kd_done;

    assign accept    = in_valid && (phase == feature_pkg::phase_idle
                                 || phase == feature_pkg::phase_load);
    assign load_we   = accept && (wcnt == WW'(IMG_W / 2 - 1));
    assign load_last = load_we && (lrow == AW'(IMG_H - 1));

    // merge the incoming word so the last one lands in the same write
    always_comb begin
        ld_row = asm_row;
        ld_row.px[2 * wcnt]     = in_data[7:0];
        ld_row.px[2 * wcnt + 1] = in_data[15:8];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wcnt <= '0;
            lrow <= '0;
        end else if (accept) begin
            if (load_we) begin
                wcnt <= '0;
                lrow <= load_last ? '0 : lrow + 1'b1;
            end else begin
                wcnt <= wcnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            asm_row <= ld_row;
        end
    end

    always_comb begin
        phase_nxt = phase;
        case (phase)
            feature_pkg::phase_idle:   if (in_valid) phase_nxt = feature_pkg::phase_load;
            feature_pkg::phase_load:   if (load_last) phase_nxt = feature_pkg::phase_blur;
            feature_pkg::phase_blur:   if (gb_done) phase_nxt = feature_pkg::phase_detect;
            feature_pkg::phase_detect: if (kd_done) phase_nxt = feature_pkg::phase_finish;
            default:                   phase_nxt = feature_pkg::phase_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= feature_pkg::phase_idle;
            done  <= 1'b0;
        end else begin
            phase <= phase_nxt;
            done  <= kd_done;     // finish phase lasts this one cycle
        end
    end

    // memory ports follow the owner of the current phase
    always_comb begin
        img_addr  = '0;
        img_we    = 1'b0;
        blur_addr = '0;
        blur_we   = 1'b0;
        case (phase)
            feature_pkg::phase_idle, feature_pkg::phase_load: begin
                img_addr = lrow;
                img_we   = load_we;
            end
            feature_pkg::phase_blur: begin
                img_addr  = gb_img_addr;
                blur_addr = gb_blur_addr;
                blur_we   = gb_blur_we;
            end
            feature_pkg::phase_detect: begin
                img_addr  = kd_row_addr;
                blur_addr = kd_row_addr;
            end
            default: begin
            end
        endcase
    end

    row_mem #(
        .DEPTH (IMG_H)
    ) img_mem (
        .clk  (clk),
        .we   (img_we),
        .addr (img_addr),
        .din  (ld_row),
        .dout (img_dout)
    );

    row_mem #(
        .DEPTH (IMG_H)
    ) blur_mem (
        .clk  (clk),
        .we   (blur_we),
        .addr (blur_addr),
        .din  (blur_din),
        .dout (blur_dout)
    );

    gaussian_blur #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) i_gaussian_blur (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (phase == feature_pkg::phase_blur),
        .img_addr  (gb_img_addr),
        .img_row   (img_dout),
        .blur_addr (gb_blur_addr),
        .blur_we   (gb_blur_we),
        .blur_row  (blur_din),
        .done      (gb_done)
    );

    keypoint_detect #(
        .IMG_W     (IMG_W),
        .IMG_H     (IMG_H),
        .THRESHOLD (THRESHOLD)
    ) i_keypoint_detect (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (phase == feature_pkg::phase_detect),
        .row_addr (kd_row_addr),
        .img_row  (img_dout),
        .blur_row (blur_dout),
        .kp_valid (out_valid),
        .kp       (out_data),
        .done     (kd_done)
    );

endmodule

/* verification/feature_core_tb.sv */
module feature_core_tb;

    localparam int IMG_W       = feature_pkg::IMG_W_DEF;
    localparam int IMG_H       = feature_pkg::IMG_H_DEF;
    localparam int THRESHOLD   = feature_pkg::THRESHOLD_DEF;
    localparam int NUM_FRAMES  = 7;
    localparam int MARGIN      = 100;
    localparam int CYCLE_LIMIT = NUM_FRAMES
                               * (IMG_W / 2 * IMG_H + 4 * IMG_H + IMG_W * IMG_H + MARGIN);

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic [15:0]            in_data;
    logic                   out_valid;
    feature_pkg::keypoint_t out_data;
    logic                   done;

    logic [31:0]            lfsr;
    feature_pkg::pix_t      img [IMG_H][IMG_W];
    feature_pkg::keypoint_t exp_q [$];       // model keypoints not yet seen
    feature_pkg::keypoint_t exp_head;
    logic                   exp_any;
    logic                   awaiting_done;
    logic                   started;
    int                     kp_errors;
    int                     ctl_errors;
    int                     cycles;

    feature_core i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [7:0] next_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function void flag_error(input bit is_kp, input string msg);
        if (is_kp) begin
            kp_errors++;
        end else begin
            ctl_errors++;
        end
        $display("FAIL %0t: %s", $time, msg);
    endfunction

    function void refresh_head();
        exp_any  = (exp_q.size() > 0);
        exp_head = exp_any ? exp_q[0] : '0;
    endfunction

    function void print_counts();
        $display("errors: keypoint %0d, control %0d, total %0d",
                 kp_errors, ctl_errors, kp_errors + ctl_errors);
    endfunction

    // kind 0 full range, 1 flat, 2 low noise, 3 spikes and pits, 4 narrow range
    task automatic make_image(input int kind);
        logic [7:0] v;
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                case (kind)
                    0:       v = next_bits(8);
                    2:       v = 8'd100 + next_bits(2);
                    4:       v = 8'd96 + next_bits(4);
                    default: v = 8'd100;
                endcase
                img[r][c] = v;
            end
        end
        if (kind == 3) begin
            img[5][7]   = 8'd220;
            img[9][3]   = 8'd5;
            img[12][12] = 8'd255;
            img[14][1]  = 8'd0;
            img[0][6]   = 8'd230;   // border spots
            img[8][15]  = 8'd5;
            img[1][14]  = 8'd200;
            img[15][9]  = 8'd250;
        end
    endtask

    task automatic build_expected();
        int                     dog [IMG_H][IMG_W];
        int                     acc;
        int                     ctr;
        int                     nb;
        bit                     is_max;
        bit                     is_min;
        feature_pkg::keypoint_t kp;
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                acc = 0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        if (r + dr >= 0 && r + dr < IMG_H && c + dc >= 0 && c + dc < IMG_W) begin
                            acc += int'(img[r + dr][c + dc]) * (dr == 0 ? 2 : 1)
                                 * (dc == 0 ? 2 : 1);
                        end
                    end
                end
                dog[r][c] = int'(img[r][c]) - acc / 16;
            end
        end
        for (int r = 1; r < IMG_H - 1; r++) begin
            for (int c = 1; c < IMG_W - 1; c++) begin
                ctr    = dog[r][c];
                is_max = 1'b1;
                is_min = 1'b1;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        nb = dog[r + dr][c + dc];
                        if ((dr != 0 || dc != 0) && nb >= ctr) is_max = 1'b0;
                        if ((dr != 0 || dc != 0) && nb <= ctr) is_min = 1'b0;
                    end
                end
                if ((ctr > THRESHOLD || ctr < -THRESHOLD) && (is_max || is_min)) begin
                    kp.row = 8'(r);
                    kp.col = 8'(c);
                    exp_q.push_back(kp);
                end
            end
        end
        refresh_head();
    endtask

    task automatic send_frame();
        for (int r = 0; r < IMG_H; r++) begin
            for (int w = 0; w < IMG_W / 2; w++) begin
                in_valid = 1'b1;
                in_data  = {img[r][2 * w + 1], img[r][2 * w]};
                started  = 1'b1;
                @(posedge clk);
                #1;
            end
        end
        in_valid = 1'b0;
    endtask

    // stray words while blur and detect run
    task automatic wait_done();
        logic [7:0] jv;
        awaiting_done = 1'b1;
        while (!done) begin
            jv       = next_bits(1);
            in_valid = jv[0];
            in_data  = {next_bits(8), next_bits(8)};
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        @(posedge clk);
        #1;
        awaiting_done = 1'b0;   // done sampled high at this edge
    endtask

    always @(posedge clk) begin
        if (rst_n && out_valid && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    kp_check: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (exp_any && out_data == exp_head))
        else flag_error(1'b1, "out_data differs from the next model keypoint");

    idle_check: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> (!out_valid && !done))
        else flag_error(1'b0, "output pulse before the first input word");

    done_check: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> awaiting_done)
        else flag_error(1'b0, "done pulsed outside the end of a frame");

    drained_check: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !exp_any)
        else flag_error(1'b0, "done pulsed with model keypoints still pending");

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: frame did not finish within %0d cycles", CYCLE_LIMIT);
        print_counts();
        $display("Regression failed");
        $finish;
    end

    initial begin
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_data       = '0;
        lfsr          = 32'h98548147;
        exp_head      = '0;
        exp_any       = 1'b0;
        awaiting_done = 1'b0;
        started       = 1'b0;
        kp_errors     = 0;
        ctl_errors    = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (8) @(posedge clk);   // quiet idle stretch
        #1;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            make_image(f % 5);
            build_expected();
            send_frame();
            wait_done();
            repeat (3) @(posedge clk);
            #1;
        end
        print_counts();
        if (kp_errors + ctl_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* src.f */
common/feature_pkg.sv
verilog/row_mem.sv
verilog/line_buffer.sv
gaussian/gaussian_blur.sv
detect/keypoint_detect.sv
verilog/feature_core.sv
verification/feature_core_tb.sv
